/* project.f */
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/wb_decoder.sv
logic/config_regs.sv
logic/gpio_port.sv
logic/volume_pwm.sv
logic/system_top.sv
verif/system_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module system_tb -Mdir obj_dir -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/Vsystem_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Testbench reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Run finished without failures"
exit 0

/* verif/system_tb.sv */
// Testbench for system_top driving a table of Wishbone accesses and checking the outputs
`timescale 1ns/10ps

module system_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int PIN_HOLD    = 5;
  localparam logic [31:0] SEED = 32'he85e_7bc1;

  logic        clk;
  logic        rst_i;
  logic [14:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic [12:0] gpio_in_i;
  logic [12:0] gpio_out_o;
  logic [12:0] gpio_oe_o;
  logic        dac_volume_o;
  logic        dac_mute_o;
  logic        dac_hp_nspk_o;

  // Stimulus table with one entry per access
  logic [14:0] row_adr[$];
  logic        row_we[$];
  logic [15:0] row_wdat[$];
  logic [15:0] row_exp[$];

  logic [15:0] rd_word;
  logic [31:0] rand_word;
  logic [12:0] pin_value;
  int          pwm_vols[3];
  int          high_cnt;
  int          exp_high;

  system_top system_top_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o),
    .gpio_in_i     (gpio_in_i),
    .gpio_out_o    (gpio_out_o),
    .gpio_oe_o     (gpio_oe_o),
    .dac_volume_o  (dac_volume_o),
    .dac_mute_o    (dac_mute_o),
    .dac_hp_nspk_o (dac_hp_nspk_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [14:0] make_addr(input logic [2:0] region, input logic [11:0] offset);
    return {region, offset};
  endfunction

  task automatic add_row(input logic [14:0] adr, input logic we, input logic [15:0] wdat,
                         input logic [15:0] exp);
    row_adr.push_back(adr);
    row_we.push_back(we);
    row_wdat.push_back(wdat);
    row_exp.push_back(exp);
  endtask

  task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // One classic cycle with inputs changed on the falling edge
  task automatic bus_access(input logic [14:0] adr, input logic we, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    wb_adr_i = adr;
    wb_dat_i = wdat;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (!wb_ack_o && wait_cnt < ACK_TIMEOUT);
    if (!wb_ack_o) begin
      $display("No acknowledge for address %h within %0d cycles", adr, ACK_TIMEOUT);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic build_table();
    // Volume after reset and then the version quarters lowest first
    add_row(make_addr(3'b000, 12'h004), 1'b0, 16'h0000, 16'd15);
    add_row(make_addr(3'b000, 12'h000), 1'b0, 16'h0000, 16'h0001);
    add_row(make_addr(3'b000, 12'h001), 1'b0, 16'h0000, 16'h000A);
    add_row(make_addr(3'b000, 12'h002), 1'b0, 16'h0000, 16'h6032);
    add_row(make_addr(3'b000, 12'h003), 1'b0, 16'h0000, 16'hBAD2);
    add_row(make_addr(3'b000, 12'h000), 1'b1, 16'hFFFF, 16'h0000);
    add_row(make_addr(3'b000, 12'h000), 1'b0, 16'h0000, 16'h0001);
    // Volume and audio control read back
    add_row(make_addr(3'b000, 12'h004), 1'b1, 16'h0123, 16'h0000);
    add_row(make_addr(3'b000, 12'h004), 1'b0, 16'h0000, 16'h0123);
    add_row(make_addr(3'b000, 12'h005), 1'b1, 16'hFFFE, 16'h0000);
    add_row(make_addr(3'b000, 12'h005), 1'b0, 16'h0000, 16'h0002);
    add_row(make_addr(3'b000, 12'h005), 1'b1, 16'h0001, 16'h0000);
    add_row(make_addr(3'b000, 12'h005), 1'b0, 16'h0000, 16'h0001);
    add_row(make_addr(3'b000, 12'h005), 1'b1, 16'h0003, 16'h0000);
    add_row(make_addr(3'b000, 12'h005), 1'b0, 16'h0000, 16'h0003);
    // Unused config offset
    add_row(make_addr(3'b000, 12'h006), 1'b1, 16'h5555, 16'h0000);
    add_row(make_addr(3'b000, 12'h006), 1'b0, 16'h0000, 16'h0000);
    // GPIO direction and output masked to 13 bits
    add_row(make_addr(3'b100, 12'h000), 1'b0, 16'h0000, 16'h0000);
    add_row(make_addr(3'b100, 12'h000), 1'b1, 16'hFFFF, 16'h0000);
    add_row(make_addr(3'b100, 12'h000), 1'b0, 16'h0000, 16'h1FFF);
    add_row(make_addr(3'b100, 12'h001), 1'b1, 16'hA5A5, 16'h0000);
    add_row(make_addr(3'b100, 12'h001), 1'b0, 16'h0000, 16'h05A5);
    add_row(make_addr(3'b100, 12'h000), 1'b1, 16'h1234, 16'h0000);
    add_row(make_addr(3'b100, 12'h000), 1'b0, 16'h0000, 16'h1234);
    // Unmapped regions answer zero and drop writes
    add_row(make_addr(3'b001, 12'h000), 1'b0, 16'h0000, 16'h0000);
    add_row(make_addr(3'b111, 12'h005), 1'b0, 16'h0000, 16'h0000);
    add_row(make_addr(3'b001, 12'h004), 1'b1, 16'h0777, 16'h0000);
    add_row(make_addr(3'b110, 12'h001), 1'b1, 16'h0000, 16'h0000);
    add_row(make_addr(3'b000, 12'h004), 1'b0, 16'h0000, 16'h0123);
    add_row(make_addr(3'b100, 12'h001), 1'b0, 16'h0000, 16'h05A5);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rand_word = $urandom(SEED);
    rst_i     = 1'b1;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    gpio_in_i = '0;
    pwm_vols  = '{0, 10, 40};
    build_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    check_word("mute after reset", 16'(dac_mute_o), 16'h0001);
    check_word("headphone after reset", 16'(dac_hp_nspk_o), 16'h0000);
    check_word("output enables after reset", 16'(gpio_oe_o), 16'h0000);
    check_word("outputs after reset", 16'(gpio_out_o), 16'h0000);

    for (int i = 0; i < row_adr.size(); i++) begin
      bus_access(row_adr[i], row_we[i], row_wdat[i], rd_word);
      if (!row_we[i]) begin
        check_word($sformatf("read data of row %0d", i), rd_word, row_exp[i]);
        // Side outputs mirror the register just read
        if (row_adr[i] == make_addr(3'b000, 12'h005)) begin
          check_word("mute output", 16'(dac_mute_o), 16'(row_exp[i][0]));
          check_word("headphone output", 16'(dac_hp_nspk_o), 16'(row_exp[i][1]));
        end
        if (row_adr[i] == make_addr(3'b100, 12'h000)) begin
          check_word("gpio_oe_o", 16'(gpio_oe_o), {3'b000, row_exp[i][12:0]});
        end
        if (row_adr[i] == make_addr(3'b100, 12'h001)) begin
          check_word("gpio_out_o", 16'(gpio_out_o), {3'b000, row_exp[i][12:0]});
        end
      end
    end

    // Random pin values through the input synchronizer
    for (int n = 0; n < 4; n++) begin
      rand_word = $urandom;
      pin_value = rand_word[12:0];
      @(negedge clk);
      gpio_in_i = pin_value;
      repeat (PIN_HOLD) @(negedge clk);
      bus_access(make_addr(3'b100, 12'h002), 1'b0, 16'h0000, rd_word);
      check_word("GPIO input read", rd_word, {3'b000, pin_value});
    end

    // PWM duty over two full periods
    foreach (pwm_vols[k]) begin
      bus_access(make_addr(3'b000, 12'h004), 1'b1, 16'(pwm_vols[k]), rd_word);
      repeat (periph_pkg::PWM_PERIOD + 1) @(negedge clk);
      high_cnt = 0;
      for (int c = 0; c < 2 * periph_pkg::PWM_PERIOD; c++) begin
        @(negedge clk);
        if (dac_volume_o) begin
          high_cnt++;
        end
      end
      exp_high = (pwm_vols[k] < periph_pkg::PWM_PERIOD) ? 2 * pwm_vols[k]
                                                        : 2 * periph_pkg::PWM_PERIOD;
      check_word($sformatf("PWM high count at volume %0d", pwm_vols[k]),
                 16'(high_cnt), 16'(exp_high));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* logic/system_top.sv */
// Peripheral system top joining the Wishbone decoder, config block, GPIO port and volume PWM
`timescale 1ns/10ps

module system_top (
  input  logic                           clk,
  input  logic                           rst_i,
  // Wishbone classic master
  input  logic [bus_pkg::ADDR_W-1:0]     wb_adr_i,
  input  bus_pkg::bus_word_t             wb_dat_i,
  output bus_pkg::bus_word_t             wb_dat_o,
  input  logic                           wb_we_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  output logic                           wb_ack_o,
  // GPIO pins
  input  logic [periph_pkg::GPIO_W-1:0]  gpio_in_i,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_out_o,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_oe_o,
  // DAC controls
  output logic                           dac_volume_o,
  output logic                           dac_mute_o,
  output logic                           dac_hp_nspk_o
);

  logic [bus_pkg::OFFSET_W-1:0] tgt_offset;
  bus_pkg::bus_word_t           tgt_dat;
  logic                         tgt_we;
  logic                         cfg_stb;
  logic                         cfg_ack;
  bus_pkg::bus_word_t           cfg_dat;
  logic                         gpio_stb;
  logic                         gpio_ack;
  bus_pkg::bus_word_t           gpio_dat;
  bus_pkg::bus_word_t           volume;

  // ------------------------------------------------------------
  // Interconnect
  // ------------------------------------------------------------
  wb_decoder wb_decoder_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .tgt_offset_o (tgt_offset),
    .tgt_dat_o    (tgt_dat),
    .tgt_we_o     (tgt_we),
    .cfg_stb_o    (cfg_stb),
    .cfg_dat_i    (cfg_dat),
    .cfg_ack_i    (cfg_ack),
    .gpio_stb_o   (gpio_stb),
    .gpio_dat_i   (gpio_dat),
    .gpio_ack_i   (gpio_ack)
  );

  // ------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------
  config_regs config_regs_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .stb_i     (cfg_stb),
    .we_i      (tgt_we),
    .offset_i  (tgt_offset),
    .dat_i     (tgt_dat),
    .dat_o     (cfg_dat),
    .ack_o     (cfg_ack),
    .volume_o  (volume),
    .mute_o    (dac_mute_o),
    .hp_nspk_o (dac_hp_nspk_o)
  );

  gpio_port gpio_port_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .stb_i      (gpio_stb),
    .we_i       (tgt_we),
    .offset_i   (tgt_offset),
    .dat_i      (tgt_dat),
    .dat_o      (gpio_dat),
    .ack_o      (gpio_ack),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  // Volume to the DAC as PWM
  volume_pwm volume_pwm_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .volume_i (volume),
    .pwm_o    (dac_volume_o)
  );

endmodule

/* logic/volume_pwm.sv */
// Volume PWM generator whose duty per period follows the configured volume word
`timescale 1ns/10ps

module volume_pwm (
  input  logic               clk,
  input  logic               rst_i,
  input  bus_pkg::bus_word_t volume_i,
  output logic               pwm_o
);

  localparam logic [periph_pkg::PWM_CNT_W-1:0] CNT_LAST =
    periph_pkg::PWM_CNT_W'(periph_pkg::PWM_PERIOD - 1);

  logic [periph_pkg::PWM_CNT_W-1:0] cnt_q;
  bus_pkg::bus_word_t               duty_q;
  logic                             wrap;

  assign wrap = (cnt_q == CNT_LAST);

  // ------------------------------------------------------------
  // Period counter and duty latch
  // ------------------------------------------------------------
  // Duty is sampled on the last count, so a new volume
  // only applies from the following period
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q  <= '0;
      duty_q <= periph_pkg::VOLUME_RESET;
    end else if (wrap) begin
      cnt_q  <= '0;
      duty_q <= volume_i;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // High while below duty, so duty >= period keeps it high
  assign pwm_o = (bus_pkg::DATA_W'(cnt_q) < duty_q);

endmodule

/* logic/gpio_port.sv */
// GPIO port with direction, output and synchronized input registers behind a Wishbone target
`timescale 1ns/10ps

module gpio_port (
  input  logic                           clk,
  input  logic                           rst_i,
  // Wishbone target
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [bus_pkg::OFFSET_W-1:0]   offset_i,
  input  bus_pkg::bus_word_t             dat_i,
  output bus_pkg::bus_word_t             dat_o,
  output logic                           ack_o,
  // Pins
  input  logic [periph_pkg::GPIO_W-1:0]  gpio_in_i,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_out_o,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_oe_o
);

  logic                           ack_q;
  logic                           access;
  bus_pkg::bus_word_t             rd_data;
  bus_pkg::bus_word_t             dat_q;
  logic [periph_pkg::GPIO_W-1:0]  dir_q;
  logic [periph_pkg::GPIO_W-1:0]  out_q;
  logic [periph_pkg::GPIO_W-1:0]  in_meta_q;
  logic [periph_pkg::GPIO_W-1:0]  in_sync_q;

  assign access = stb_i & ~ack_q;

  // ------------------------------------------------------------
  // Two-flop input synchronizer
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // ------------------------------------------------------------
  // Read mux with upper bits zero
  // ------------------------------------------------------------
  always_comb begin
    case (offset_i)
      periph_pkg::GPIO_DIR: rd_data = bus_pkg::DATA_W'(dir_q);
      periph_pkg::GPIO_OUT: rd_data = bus_pkg::DATA_W'(out_q);
      periph_pkg::GPIO_IN:  rd_data = bus_pkg::DATA_W'(in_sync_q);
      default:              rd_data = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Handshake, direction and output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      dir_q <= '0;
      out_q <= '0;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        case (offset_i)
          periph_pkg::GPIO_DIR: dir_q <= dat_i[periph_pkg::GPIO_W-1:0];
          periph_pkg::GPIO_OUT: out_q <= dat_i[periph_pkg::GPIO_W-1:0];
          // Input register is read-only
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  assign dat_o      = dat_q;
  assign ack_o      = ack_q;
  assign gpio_oe_o  = dir_q;
  assign gpio_out_o = out_q;

endmodule

/* logic/config_regs.sv */
// Configuration registers with read-only version quarters plus volume and audio control
`timescale 1ns/10ps

module config_regs (
  input  logic                         clk,
  input  logic                         rst_i,
  // Wishbone target
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic [bus_pkg::OFFSET_W-1:0] offset_i,
  input  bus_pkg::bus_word_t           dat_i,
  output bus_pkg::bus_word_t           dat_o,
  output logic                         ack_o,
  // Audio settings
  output bus_pkg::bus_word_t           volume_o,
  output logic                         mute_o,
  output logic                         hp_nspk_o
);

  logic                                  ack_q;
  logic                                  access;
  bus_pkg::bus_word_t                    rd_data;
  bus_pkg::bus_word_t                    dat_q;
  bus_pkg::bus_word_t                    volume_q;
  logic [periph_pkg::AUDIO_CTRL_W-1:0]   audio_ctrl_q;

  // New access only when no ack is pending
  assign access = stb_i & ~ack_q;

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    case (offset_i)
      periph_pkg::CFG_VERSION_0:  rd_data = periph_pkg::VERSION[15:0];
      periph_pkg::CFG_VERSION_1:  rd_data = periph_pkg::VERSION[31:16];
      periph_pkg::CFG_VERSION_2:  rd_data = periph_pkg::VERSION[47:32];
      periph_pkg::CFG_VERSION_3:  rd_data = periph_pkg::VERSION[63:48];
      periph_pkg::CFG_VOLUME:     rd_data = volume_q;
      periph_pkg::CFG_AUDIO_CTRL: rd_data = bus_pkg::DATA_W'(audio_ctrl_q);
      default:                    rd_data = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Handshake and writable registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q        <= 1'b0;
      volume_q     <= periph_pkg::VOLUME_RESET;
      audio_ctrl_q <= periph_pkg::AUDIO_CTRL_RESET;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        case (offset_i)
          periph_pkg::CFG_VOLUME:     volume_q     <= dat_i;
          periph_pkg::CFG_AUDIO_CTRL: audio_ctrl_q <= dat_i[periph_pkg::AUDIO_CTRL_W-1:0];
          // Version and unused offsets ignore writes
          default: ;
        endcase
      end
    end
  end

  // Read data captured with the request and held through ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

  assign volume_o  = volume_q;
  assign mute_o    = audio_ctrl_q[periph_pkg::AUDIO_MUTE_BIT];
  assign hp_nspk_o = audio_ctrl_q[periph_pkg::AUDIO_HP_BIT];

endmodule

/* logic/wb_decoder.sv */
// Wishbone decoder that routes the master to the targets and answers unmapped addresses
`timescale 1ns/10ps

module wb_decoder (
  input  logic                                clk,
  input  logic                                rst_i,
  // Master side
  input  logic [bus_pkg::ADDR_W-1:0]          wb_adr_i,
  input  bus_pkg::bus_word_t                  wb_dat_i,
  input  logic                                wb_we_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  output bus_pkg::bus_word_t                  wb_dat_o,
  output logic                                wb_ack_o,
  // Shared target request lines
  output logic [bus_pkg::OFFSET_W-1:0]        tgt_offset_o,
  output bus_pkg::bus_word_t                  tgt_dat_o,
  output logic                                tgt_we_o,
  // Configuration target
  output logic                                cfg_stb_o,
  input  bus_pkg::bus_word_t                  cfg_dat_i,
  input  logic                                cfg_ack_i,
  // GPIO target
  output logic                                gpio_stb_o,
  input  bus_pkg::bus_word_t                  gpio_dat_i,
  input  logic                                gpio_ack_i
);

  bus_pkg::bus_addr_u adr;
  logic               req;
  logic               hit_cfg;
  logic               hit_gpio;
  logic               unmapped_stb;
  logic               unmapped_ack_q;

  assign adr.raw = wb_adr_i;

  // ------------------------------------------------------------
  // Region decode
  // ------------------------------------------------------------
  assign req      = wb_cyc_i & wb_stb_i;
  assign hit_cfg  = (adr.field.region == bus_pkg::REGION_CFG);
  assign hit_gpio = (adr.field.region == bus_pkg::REGION_GPIO);

  assign cfg_stb_o    = req & hit_cfg;
  assign gpio_stb_o   = req & hit_gpio;
  assign unmapped_stb = req & ~hit_cfg & ~hit_gpio;

  // Same request lines go to every target
  assign tgt_offset_o = adr.field.offset;
  assign tgt_dat_o    = wb_dat_i;
  assign tgt_we_o     = wb_we_i;

  // ------------------------------------------------------------
  // Unmapped responder
  // ------------------------------------------------------------
  // One-cycle ack that drops writes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      unmapped_ack_q <= 1'b0;
    end else begin
      unmapped_ack_q <= unmapped_stb & ~unmapped_ack_q;
    end
  end

  // ------------------------------------------------------------
  // Return path
  // ------------------------------------------------------------
  assign wb_ack_o = cfg_ack_i | gpio_ack_i | unmapped_ack_q;

  // Data of the acknowledging target or zero
  always_comb begin
    if (cfg_ack_i) begin
      wb_dat_o = cfg_dat_i;
    end else if (gpio_ack_i) begin
      wb_dat_o = gpio_dat_i;
    end else begin
      wb_dat_o = '0;
    end
  end

endmodule

/* logic/periph_pkg.sv */
// Register offsets, reset values and PWM constants of the configuration, GPIO and PWM blocks

package periph_pkg;

  // ------------------------------------------------------------
  // Configuration region
  // ------------------------------------------------------------
  // Version word with the lowest quarter first
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_VERSION_0  = 12'h000;
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_VERSION_1  = 12'h001;
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_VERSION_2  = 12'h002;
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_VERSION_3  = 12'h003;
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_VOLUME     = 12'h004;
  localparam logic [bus_pkg::OFFSET_W-1:0] CFG_AUDIO_CTRL = 12'h005;

  localparam logic [63:0] VERSION = 64'hBAD2_6032_000A_0001;

  // Audio control bits
  localparam int AUDIO_CTRL_W   = 2;
  localparam int AUDIO_MUTE_BIT = 0;
  localparam int AUDIO_HP_BIT   = 1;

  // Muted with the speaker selected
  localparam logic [AUDIO_CTRL_W-1:0] AUDIO_CTRL_RESET = 2'b01;
  localparam logic [bus_pkg::DATA_W-1:0] VOLUME_RESET  = 16'd15;

  // ------------------------------------------------------------
  // GPIO region
  // ------------------------------------------------------------
  localparam logic [bus_pkg::OFFSET_W-1:0] GPIO_DIR = 12'h000;
  localparam logic [bus_pkg::OFFSET_W-1:0] GPIO_OUT = 12'h001;
  localparam logic [bus_pkg::OFFSET_W-1:0] GPIO_IN  = 12'h002;

  localparam int GPIO_W = 13;

  // ------------------------------------------------------------
  // Volume PWM
  // ------------------------------------------------------------
  localparam int PWM_PERIOD = 30;
  localparam int PWM_CNT_W  = $clog2(PWM_PERIOD);

endpackage

/* logic/bus_pkg.sv */
// Wishbone bus widths, region codes and address view shared by decoder, targets and top

package bus_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int ADDR_W   = 15;
  localparam int DATA_W   = 16;
  localparam int REGION_W = 3;
  localparam int OFFSET_W = ADDR_W - REGION_W;

  // ------------------------------------------------------------
  // Region codes in the upper three address bits
  // ------------------------------------------------------------
  // Configuration block at 0x0000
  localparam logic [REGION_W-1:0] REGION_CFG  = 3'b000;
  // GPIO port at 0x4000
  localparam logic [REGION_W-1:0] REGION_GPIO = 3'b100;

  // One data word on the bus
  typedef logic [DATA_W-1:0] bus_word_t;

  // Address word seen either whole or as region over offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [OFFSET_W-1:0] offset;
    } field;
  } bus_addr_u;

endpackage
